// ==== dv/iq_shaping_tb.sv ====
`timescale 1ns/100ps

module iq_shaping_tb;

    import tx_shaping_pkg::*;

    localparam int NUM_TAPS = 8;
    localparam int HIST     = NUM_TAPS + 3;

    logic      clk;
    logic      rst_n_sync_wire;
    logic      new_symbol_i;
    sample_t   sym_i_i;
    sample_t   sym_q_i;
    logic      reg_en_i;
    logic      reg_we_i;
    reg_addr_t reg_addr_i;
    reg_data_t reg_wdata_i;
    reg_data_t reg_rdata_o;
    dac_t      i_out_o;
    dac_t      q_out_o;
    logic      out_valid_o;

    // Reference model state
    int        hist_i [HIST];
    int        hist_q [HIST];
    bit        hist_s [HIST];
    int        mc_i   [NUM_TAPS];
    int        mc_q   [NUM_TAPS];
    int        cm1_i  [NUM_TAPS];
    int        cm1_q  [NUM_TAPS];
    int        cm2_i  [NUM_TAPS];
    int        cm2_q  [NUM_TAPS];
    reg_data_t rd_exp;
    int        exp_sum_i;
    int        exp_sum_q;
    bit        exp_valid;
    int        addr_int;

    logic [31:0] rng;
    int          ci_set [NUM_TAPS];
    int          cq_set [NUM_TAPS];
    int          n_edges;
    int          gap;

    iq_shaping_top #(.NUM_TAPS(NUM_TAPS)) i_iq_shaping_top (
        .clk             (clk),
        .rst_n_sync_wire (rst_n_sync_wire),
        .new_symbol_i    (new_symbol_i),
        .sym_i_i         (sym_i_i),
        .sym_q_i         (sym_q_i),
        .reg_en_i        (reg_en_i),
        .reg_we_i        (reg_we_i),
        .reg_addr_i      (reg_addr_i),
        .reg_wdata_i     (reg_wdata_i),
        .reg_rdata_o     (reg_rdata_o),
        .i_out_o         (i_out_o),
        .q_out_o         (q_out_o),
        .out_valid_o     (out_valid_o)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int unsigned rand_next();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Divide toward zero, then clamp to the 10-bit DAC range
    function automatic int scale_expected(input int s);
        int r;
        r = s / (1 << OUT_SHIFT);
        if (r > 511) begin
            r = 511;
        end else if (r < -512) begin
            r = -512;
        end
        return r;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input int addr, input int data);
        reg_en_i    = 1'b1;
        reg_we_i    = 1'b1;
        reg_addr_i  = reg_addr_t'(addr);
        reg_wdata_i = reg_data_t'(data);
        tick();
        reg_en_i    = 1'b0;
        reg_we_i    = 1'b0;
    endtask

    task automatic read_check(input int addr, input int expected);
        reg_en_i   = 1'b1;
        reg_we_i   = 1'b0;
        reg_addr_i = reg_addr_t'(addr);
        tick();
        reg_en_i   = 1'b0;
        assert (reg_rdata_o == reg_data_t'(expected))
        else report_mismatch($sformatf("read addr %0d got %0h expected %0h",
                                       addr, reg_rdata_o, reg_data_t'(expected)));
    endtask

    task automatic send_symbol(input int si, input int sq);
        new_symbol_i = 1'b1;
        sym_i_i      = sample_t'(si);
        sym_q_i      = sample_t'(sq);
        tick();
        new_symbol_i = 1'b0;
    endtask

    task automatic wait_window_closed();
        int n;
        n = 0;
        while (out_valid_o) begin
            tick();
            n++;
            if (n > 64) begin
                report_error("output window did not close in time");
            end
        end
    endtask

    task automatic program_all(input int ci, input int cq);
        for (int k = 0; k < NUM_TAPS; k++) begin
            write_reg(int'(COEFF_I_BASE) + k, ci);
            write_reg(int'(COEFF_Q_BASE) + k, cq);
        end
    endtask

    // Model update on each edge, reads see the bank before this edge's write
    always @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            for (int k = 0; k < HIST; k++) begin
                hist_i[k] = 0;
                hist_q[k] = 0;
                hist_s[k] = 1'b0;
            end
            for (int k = 0; k < NUM_TAPS; k++) begin
                mc_i[k]  = 0;
                mc_q[k]  = 0;
                cm1_i[k] = 0;
                cm1_q[k] = 0;
                cm2_i[k] = 0;
                cm2_q[k] = 0;
            end
            rd_exp = '0;
        end else begin
            for (int k = HIST - 1; k > 0; k--) begin
                hist_i[k] = hist_i[k-1];
                hist_q[k] = hist_q[k-1];
                hist_s[k] = hist_s[k-1];
            end
            hist_s[0] = new_symbol_i;
            hist_i[0] = new_symbol_i ? int'(sym_i_i) : 0;
            hist_q[0] = new_symbol_i ? int'(sym_q_i) : 0;
            cm2_i = cm1_i;
            cm2_q = cm1_q;
            cm1_i = mc_i;
            cm1_q = mc_q;
            addr_int = int'(reg_addr_i);
            rd_exp = '0;
            if (addr_int >= int'(COEFF_I_BASE) && addr_int < int'(COEFF_I_BASE) + NUM_TAPS) begin
                if (reg_en_i && !reg_we_i) begin
                    rd_exp = reg_data_t'(mc_i[addr_int - int'(COEFF_I_BASE)]);
                end
                if (reg_en_i && reg_we_i) begin
                    mc_i[addr_int - int'(COEFF_I_BASE)] = int'(coeff_t'(reg_wdata_i));
                end
            end else if (addr_int >= int'(COEFF_Q_BASE) &&
                         addr_int < int'(COEFF_Q_BASE) + NUM_TAPS) begin
                if (reg_en_i && !reg_we_i) begin
                    rd_exp = reg_data_t'(mc_q[addr_int - int'(COEFF_Q_BASE)]);
                end
                if (reg_en_i && reg_we_i) begin
                    mc_q[addr_int - int'(COEFF_Q_BASE)] = int'(coeff_t'(reg_wdata_i));
                end
            end
        end
    end

    // Outputs after edge e use symbols of edges e-3-k and the bank after edge e-2
    always @(negedge clk) begin
        if (rst_n_sync_wire) begin
            exp_valid = 1'b0;
            exp_sum_i = 0;
            exp_sum_q = 0;
            for (int k = 0; k < NUM_TAPS; k++) begin
                exp_valid = exp_valid | hist_s[3+k];
                exp_sum_i = exp_sum_i + cm2_i[k] * hist_i[3+k];
                exp_sum_q = exp_sum_q + cm2_q[k] * hist_q[3+k];
            end
            assert (out_valid_o == exp_valid)
            else report_mismatch($sformatf("out_valid_o is %0b", out_valid_o));
            if (exp_valid) begin
                assert (i_out_o == dac_t'(scale_expected(exp_sum_i)))
                else report_mismatch($sformatf("i_out_o %0d expected %0d",
                                               i_out_o, scale_expected(exp_sum_i)));
                assert (q_out_o == dac_t'(scale_expected(exp_sum_q)))
                else report_mismatch($sformatf("q_out_o %0d expected %0d",
                                               q_out_o, scale_expected(exp_sum_q)));
            end
            assert (reg_rdata_o == rd_exp)
            else report_mismatch($sformatf("reg_rdata_o %0h expected %0h", reg_rdata_o, rd_exp));
        end
    end

    // Closed window keeps both DAC words at zero
    assert property (@(negedge clk) disable iff (!rst_n_sync_wire)
                     !out_valid_o |-> (i_out_o == '0 && q_out_o == '0))
    else report_mismatch("outputs not zero while window closed");

    initial begin
        rst_n_sync_wire = 1'b0;
        new_symbol_i    = 1'b0;
        sym_i_i         = '0;
        sym_q_i         = '0;
        reg_en_i        = 1'b0;
        reg_we_i        = 1'b0;
        reg_addr_i      = '0;
        reg_wdata_i     = '0;
        rng             = 32'h14790487;
        repeat (2) @(posedge clk);
        #1;
        rst_n_sync_wire = 1'b1;

        // Reset state
        assert (!out_valid_o && i_out_o == '0 && q_out_o == '0 && reg_rdata_o == '0)
        else report_mismatch("outputs not zero after reset");
        for (int k = 0; k < NUM_TAPS; k++) begin
            read_check(int'(COEFF_I_BASE) + k, 0);
            read_check(int'(COEFF_Q_BASE) + k, 0);
        end

        // Register access with distinct values
        for (int k = 0; k < NUM_TAPS; k++) begin
            ci_set[k] = k * 17 + 3;
            cq_set[k] = -(k * 13 + 5);
            write_reg(int'(COEFF_I_BASE) + k, ci_set[k]);
            write_reg(int'(COEFF_Q_BASE) + k, cq_set[k]);
        end
        for (int k = 0; k < NUM_TAPS; k++) begin
            read_check(int'(COEFF_I_BASE) + k, ci_set[k]);
            read_check(int'(COEFF_Q_BASE) + k, cq_set[k]);
        end
        read_check(127, 0);
        read_check(136, 0);
        read_check(600, 0);
        read_check(264, 0);
        write_reg(127, 8'h55);
        write_reg(136, 8'h55);
        write_reg(600, 8'h55);
        for (int k = 0; k < NUM_TAPS; k++) begin
            read_check(int'(COEFF_I_BASE) + k, ci_set[k]);
            read_check(int'(COEFF_Q_BASE) + k, cq_set[k]);
        end

        // Impulse response, tap k shows after edge 3+k
        send_symbol(5, -3);
        tick();
        tick();
        for (int k = 0; k < NUM_TAPS; k++) begin
            tick();
            assert (i_out_o == dac_t'(scale_expected(ci_set[k] * 5)) &&
                    q_out_o == dac_t'(scale_expected(cq_set[k] * -3)))
            else report_mismatch($sformatf("impulse tap %0d", k));
        end
        wait_window_closed();

        // Rounding toward zero on negative sums
        program_all(0, 0);
        write_reg(int'(COEFF_I_BASE), 3);
        write_reg(int'(COEFF_Q_BASE), 1);
        send_symbol(-3, -3);
        repeat (3) tick();
        assert (i_out_o == -10'sd2 && q_out_o == 10'sd0)
        else report_mismatch("negative rounding");
        wait_window_closed();

        // Saturation at both ends
        program_all(-128, -128);
        repeat (10) send_symbol(-8, -8);
        assert (i_out_o == 10'sd511 && q_out_o == 10'sd511)
        else report_mismatch("positive saturation");
        wait_window_closed();
        repeat (10) send_symbol(7, 7);
        assert (i_out_o == -10'sd512 && q_out_o == -10'sd512)
        else report_mismatch("negative saturation");
        wait_window_closed();

        // Output window timing, with the bank changed while closed
        program_all(int'(rand_next() % 256), int'(rand_next() % 256));
        send_symbol(3, -4);
        n_edges = 0;
        while (!out_valid_o) begin
            tick();
            n_edges++;
            if (n_edges > 20) begin
                report_error("output window never opened");
            end
        end
        assert (n_edges == 3) else report_mismatch($sformatf("window opened at %0d", n_edges));
        while (out_valid_o) begin
            tick();
            n_edges++;
            if (n_edges > 40) begin
                report_error("output window did not close in time");
            end
        end
        assert (n_edges == 3 + NUM_TAPS)
        else report_mismatch($sformatf("window closed at edge %0d", n_edges));

        // Random streams with occasional coefficient writes in flight
        for (int k = 0; k < NUM_TAPS; k++) begin
            write_reg(int'(COEFF_I_BASE) + k, int'(rand_next() % 256));
            write_reg(int'(COEFF_Q_BASE) + k, int'(rand_next() % 256));
        end
        for (int n = 0; n < 400; n++) begin
            send_symbol(int'(rand_next() % 16), int'(rand_next() % 16));
            gap = int'(rand_next() % 4);
            if (rand_next() % 16 == 0) begin
                write_reg(int'(COEFF_Q_BASE) + int'(rand_next() % NUM_TAPS),
                          int'(rand_next() % 256));
            end
            repeat (gap) tick();
        end
        wait_window_closed();
        repeat (4) tick();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== iq_shaping.f ====
logic/tx_shaping_pkg.sv
logic/symbol_upsampler.sv
logic/coeff_bank.sv
logic/fir_shaper.sv
logic/tx_output_stage.sv
logic/iq_shaping_top.sv
dv/iq_shaping_tb.sv

// ==== logic/coeff_bank.sv ====
`timescale 1ns/100ps

module coeff_bank #(
    parameter int NUM_TAPS = 8
) (
    input  logic                                    clk,
    input  logic                                    rst_n_sync_wire,
    input  logic                                    reg_en_i,
    input  logic                                    reg_we_i,
    input  tx_shaping_pkg::reg_addr_t               reg_addr_i,
    input  tx_shaping_pkg::reg_data_t               reg_wdata_i,
    output tx_shaping_pkg::reg_data_t               reg_rdata_o,
    output tx_shaping_pkg::coeff_t [NUM_TAPS-1:0]   coeff_i_o,
    output tx_shaping_pkg::coeff_t [NUM_TAPS-1:0]   coeff_q_o
);

    import tx_shaping_pkg::*;

    localparam int IDX_W = (NUM_TAPS > 1) ? $clog2(NUM_TAPS) : 1;

    coeff_t [NUM_TAPS-1:0] coeff_i_q;
    coeff_t [NUM_TAPS-1:0] coeff_q_q;
    reg_region_e           region;
    reg_addr_t             offset;
    logic [IDX_W-1:0]      index;
    reg_data_t             rd_data;

    // Address decode into region and local tap index
    always_comb begin
        region = REGION_NONE;
        offset = '0;
        if (reg_addr_i >= COEFF_I_BASE && reg_addr_i < COEFF_I_BASE + reg_addr_t'(NUM_TAPS)) begin
            region = REGION_COEFF_I;
            offset = reg_addr_i - COEFF_I_BASE;
        end else if (reg_addr_i >= COEFF_Q_BASE &&
                     reg_addr_i < COEFF_Q_BASE + reg_addr_t'(NUM_TAPS)) begin
            region = REGION_COEFF_Q;
            offset = reg_addr_i - COEFF_Q_BASE;
        end
        index = IDX_W'(offset);
    end

    // Selected coefficient, zero for unmapped addresses
    always_comb begin
        case (region)
            REGION_COEFF_I: rd_data = reg_data_t'(coeff_i_q[index]);
            REGION_COEFF_Q: rd_data = reg_data_t'(coeff_q_q[index]);
            default:        rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            coeff_i_q   <= '0;
            coeff_q_q   <= '0;
            reg_rdata_o <= '0;
        end else begin
            if (reg_en_i && reg_we_i) begin
                case (region)
                    REGION_COEFF_I: coeff_i_q[index] <= coeff_t'(reg_wdata_i);
                    REGION_COEFF_Q: coeff_q_q[index] <= coeff_t'(reg_wdata_i);
                    default: ;
                endcase
            end
            // Read data is only held for the cycle after the read strobe
            reg_rdata_o <= (reg_en_i && !reg_we_i) ? rd_data : '0;
        end
    end

    assign coeff_i_o = coeff_i_q;
    assign coeff_q_o = coeff_q_q;

endmodule

// ==== logic/fir_shaper.sv ====
`timescale 1ns/100ps

module fir_shaper #(
    parameter int NUM_TAPS = 8
) (
    input  logic                                    clk,
    input  logic                                    rst_n_sync_wire,
    input  tx_shaping_pkg::iq_sym_t                 sym_i,
    input  tx_shaping_pkg::coeff_t [NUM_TAPS-1:0]   coeff_i_i,
    input  tx_shaping_pkg::coeff_t [NUM_TAPS-1:0]   coeff_q_i,
    output tx_shaping_pkg::iq_acc_t                 acc_o
);

    import tx_shaping_pkg::*;

    // Registered part of the delay line, tap 0 is the incoming sample
    sample_t [NUM_TAPS-1:1] line_i;
    sample_t [NUM_TAPS-1:1] line_q;

    // Full tap view of both lanes
    sample_t [NUM_TAPS-1:0] taps_i;
    sample_t [NUM_TAPS-1:0] taps_q;

    acc_t sum_i;
    acc_t sum_q;

    always_ff @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            line_i <= '0;
            line_q <= '0;
        end else begin
            line_i[1] <= sym_i.i;
            line_q[1] <= sym_i.q;
            for (int k = 2; k < NUM_TAPS; k++) begin
                line_i[k] <= line_i[k-1];
                line_q[k] <= line_q[k-1];
            end
        end
    end

    always_comb begin
        taps_i[0] = sym_i.i;
        taps_q[0] = sym_i.q;
        for (int k = 1; k < NUM_TAPS; k++) begin
            taps_i[k] = line_i[k];
            taps_q[k] = line_q[k];
        end
    end

    // Sum of products per lane, operands sign extended to the accumulator
    always_comb begin
        sum_i = '0;
        sum_q = '0;
        for (int k = 0; k < NUM_TAPS; k++) begin
            sum_i = sum_i + acc_t'(coeff_i_i[k]) * acc_t'(taps_i[k]);
            sum_q = sum_q + acc_t'(coeff_q_i[k]) * acc_t'(taps_q[k]);
        end
    end

    // Result register, fresh lines up with the tap-0 term
    always_ff @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            acc_o <= '0;
        end else begin
            acc_o.i     <= sum_i;
            acc_o.q     <= sum_q;
            acc_o.fresh <= sym_i.fresh;
        end
    end

endmodule

// ==== logic/iq_shaping_top.sv ====
`timescale 1ns/100ps

module iq_shaping_top #(
    parameter int NUM_TAPS = 8
) (
    input  logic                        clk,
    input  logic                        rst_n_sync_wire,
    input  logic                        new_symbol_i,
    input  tx_shaping_pkg::sample_t     sym_i_i,
    input  tx_shaping_pkg::sample_t     sym_q_i,
    input  logic                        reg_en_i,
    input  logic                        reg_we_i,
    input  tx_shaping_pkg::reg_addr_t   reg_addr_i,
    input  tx_shaping_pkg::reg_data_t   reg_wdata_i,
    output tx_shaping_pkg::reg_data_t   reg_rdata_o,
    output tx_shaping_pkg::dac_t        i_out_o,
    output tx_shaping_pkg::dac_t        q_out_o,
    output logic                        out_valid_o
);

    import tx_shaping_pkg::*;

    iq_sym_t               up_sym;
    iq_acc_t               fir_acc;
    coeff_t [NUM_TAPS-1:0] coeff_i;
    coeff_t [NUM_TAPS-1:0] coeff_q;

    symbol_upsampler i_symbol_upsampler (
        .clk             (clk),
        .rst_n_sync_wire (rst_n_sync_wire),
        .new_symbol_i    (new_symbol_i),
        .sym_i_i         (sym_i_i),
        .sym_q_i         (sym_q_i),
        .sym_o           (up_sym)
    );

    coeff_bank #(.NUM_TAPS(NUM_TAPS)) i_coeff_bank (
        .clk             (clk),
        .rst_n_sync_wire (rst_n_sync_wire),
        .reg_en_i        (reg_en_i),
        .reg_we_i        (reg_we_i),
        .reg_addr_i      (reg_addr_i),
        .reg_wdata_i     (reg_wdata_i),
        .reg_rdata_o     (reg_rdata_o),
        .coeff_i_o       (coeff_i),
        .coeff_q_o       (coeff_q)
    );

    fir_shaper #(.NUM_TAPS(NUM_TAPS)) i_fir_shaper (
        .clk             (clk),
        .rst_n_sync_wire (rst_n_sync_wire),
        .sym_i           (up_sym),
        .coeff_i_i       (coeff_i),
        .coeff_q_i       (coeff_q),
        .acc_o           (fir_acc)
    );

    tx_output_stage #(.NUM_TAPS(NUM_TAPS)) i_tx_output_stage (
        .clk             (clk),
        .rst_n_sync_wire (rst_n_sync_wire),
        .acc_i           (fir_acc),
        .i_out_o         (i_out_o),
        .q_out_o         (q_out_o),
        .out_valid_o     (out_valid_o)
    );

endmodule

// ==== logic/symbol_upsampler.sv ====
`timescale 1ns/100ps

module symbol_upsampler (
    input  logic                      clk,
    input  logic                      rst_n_sync_wire,
    input  logic                      new_symbol_i,
    input  tx_shaping_pkg::sample_t   sym_i_i,
    input  tx_shaping_pkg::sample_t   sym_q_i,
    output tx_shaping_pkg::iq_sym_t   sym_o
);

    import tx_shaping_pkg::*;

    // Input capture stage
    logic    strobe_q;
    sample_t cap_i_q;
    sample_t cap_q_q;

    always_ff @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= new_symbol_i;
        end
    end

    always_ff @(posedge clk) begin
        cap_i_q <= sym_i_i;
        cap_q_q <= sym_q_i;
    end

    // Zero stuffing, a real symbol only in the cycle after its strobe
    always_ff @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            sym_o <= '0;
        end else if (strobe_q) begin
            sym_o.i     <= cap_i_q;
            sym_o.q     <= cap_q_q;
            sym_o.fresh <= 1'b1;
        end else begin
            sym_o <= '0;
        end
    end

endmodule

// ==== logic/tx_output_stage.sv ====
`timescale 1ns/100ps

module tx_output_stage #(
    parameter int NUM_TAPS = 8
) (
    input  logic                      clk,
    input  logic                      rst_n_sync_wire,
    input  tx_shaping_pkg::iq_acc_t   acc_i,
    output tx_shaping_pkg::dac_t      i_out_o,
    output tx_shaping_pkg::dac_t      q_out_o,
    output logic                      out_valid_o
);

    import tx_shaping_pkg::*;

    localparam int   CNT_W      = (NUM_TAPS > 1) ? $clog2(NUM_TAPS) : 1;
    localparam int   DAC_MAX    = (1 << ($bits(dac_t) - 1)) - 1;
    localparam int   DAC_MIN    = -(1 << ($bits(dac_t) - 1));
    localparam acc_t ROUND_BIAS = acc_t'((1 << OUT_SHIFT) - 1);

    tx_state_e        state_q;
    tx_state_e        state_d;
    logic [CNT_W-1:0] idle_cnt_q;
    logic [CNT_W-1:0] idle_cnt_d;

    // Divide with rounding toward zero, then clamp to the DAC range
    function automatic dac_t scale_sat(input acc_t value);
        acc_t biased;
        acc_t shifted;
        biased  = (value < 0) ? value + ROUND_BIAS : value;
        shifted = biased >>> OUT_SHIFT;
        if (int'(shifted) > DAC_MAX) begin
            return dac_t'(DAC_MAX);
        end else if (int'(shifted) < DAC_MIN) begin
            return dac_t'(DAC_MIN);
        end
        return dac_t'(shifted);
    endfunction

    // Window opens on a fresh result, closes after NUM_TAPS quiet cycles
    always_comb begin
        state_d    = state_q;
        idle_cnt_d = idle_cnt_q;
        case (state_q)
            TX_IDLE: begin
                if (acc_i.fresh) begin
                    state_d    = TX_ACTIVE;
                    idle_cnt_d = '0;
                end
            end
            TX_ACTIVE: begin
                if (acc_i.fresh) begin
                    idle_cnt_d = '0;
                end else if (idle_cnt_q == CNT_W'(NUM_TAPS - 1)) begin
                    state_d = TX_IDLE;
                end else begin
                    idle_cnt_d = idle_cnt_q + 1'b1;
                end
            end
            default: state_d = TX_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            state_q    <= TX_IDLE;
            idle_cnt_q <= '0;
            i_out_o    <= '0;
            q_out_o    <= '0;
        end else begin
            state_q    <= state_d;
            idle_cnt_q <= idle_cnt_d;
            // Outputs follow the window state of the same edge
            i_out_o    <= (state_d == TX_ACTIVE) ? scale_sat(acc_i.i) : '0;
            q_out_o    <= (state_d == TX_ACTIVE) ? scale_sat(acc_i.q) : '0;
        end
    end

    assign out_valid_o = (state_q == TX_ACTIVE);

endmodule

// ==== logic/tx_shaping_pkg.sv ====
package tx_shaping_pkg;

    // Datapath word types
    typedef logic signed [3:0]  sample_t;
    typedef logic signed [7:0]  coeff_t;
    typedef logic signed [15:0] acc_t;
    typedef logic signed [9:0]  dac_t;

    // Register port word types
    typedef logic [9:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    // Zero-stuffed symbol pair, fresh marks a real symbol
    typedef struct packed {
        sample_t i;
        sample_t q;
        logic    fresh;
    } iq_sym_t;

    // Filter result pair, fresh follows the tap-0 result
    typedef struct packed {
        acc_t i;
        acc_t q;
        logic fresh;
    } iq_acc_t;

    // Output window FSM
    typedef enum logic {
        TX_IDLE   = 1'b0,
        TX_ACTIVE = 1'b1
    } tx_state_e;

    // Decoded register address region
    typedef enum logic [1:0] {
        REGION_NONE    = 2'd0,
        REGION_COEFF_I = 2'd1,
        REGION_COEFF_Q = 2'd2
    } reg_region_e;

    // Address map
    localparam reg_addr_t COEFF_I_BASE = 10'd128;
    localparam reg_addr_t COEFF_Q_BASE = 10'd256;

    // Output scaling, divide by 2**OUT_SHIFT
    localparam int OUT_SHIFT = 2;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f iq_shaping.f \
    --top-module iq_shaping_tb -o iq_shaping_sim \
    || { echo "Build failed"; exit 1; }

./obj_dir/iq_shaping_sim > sim.log 2>&1
cat sim.log

grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation ended without a result"; exit 1; }
